//--- cpuPkg.sv
//////////////////////////////////////////////////////////////////////
// Shared word width, encodings and instruction views of the core
// Opcodes 3, 6 and 7 have no entry here and execute as no-ops
//////////////////////////////////////////////////////////////////////
package cpuPkg;

  localparam int DataWidth = 16;          // Machine word

  typedef enum logic [3:0] {
    opAdd = 4'h0,
    opSub = 4'h1,
    opXor = 4'h2,
    opSll = 4'h4,
    opSra = 4'h5,
    opLw  = 4'h8,
    opSw  = 4'h9,
    opLlb = 4'hA,
    opLhb = 4'hB,
    opB   = 4'hC,
    opBr  = 4'hD,                         // Jump to register
    opPcs = 4'hE,
    opHlt = 4'hF
  } opcodeT;

  // Branch conditions against Z, V, N
  typedef enum logic [2:0] {
    condNe     = 3'd0,
    condEq     = 3'd1,
    condGt     = 3'd2,
    condLt     = 3'd3,
    condGe     = 3'd4,
    condLe     = 3'd5,
    condOv     = 3'd6,
    condAlways = 3'd7
  } condT;

  // ALU, shifts, loads and stores
  typedef struct packed {
    opcodeT     op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;                       // Shift amount or mem offset too
  } regFmtT;

  // LLB and LHB
  typedef struct packed {
    opcodeT     op;
    logic [3:0] rd;
    logic [7:0] imm;
  } immFmtT;

  typedef struct packed {
    opcodeT     op;
    condT       cond;
    logic [8:0] offset;                   // Word offset, signed
  } brFmtT;

  typedef union packed {
    regFmtT rFmt;
    immFmtT iFmt;
    brFmtT  bFmt;
  } instrT;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flagsT;

endpackage

//--- memBusIf.sv
//////////////////////////////////////////////////////////////////////
// Request and grant bus to memory, byte addressed
// A read answers with rvalid one cycle after its grant
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface memBusIf;
  import cpuPkg::*;

  // Requester side
  logic                 req;              // Held until gnt
  logic                 we;
  logic [15:0]          addr;             // Byte address
  logic [DataWidth-1:0] wdata;

  // Responder side
  logic                 gnt;              // Write done at grant
  logic [DataWidth-1:0] rdata;
  logic                 rvalid;           // One cycle after read grant

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  // Also the memory's own view of its port
  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

//--- fetchUnit.sv
//////////////////////////////////////////////////////////////////////
// One read in flight at most, one prefetched instruction held
// Stale responses after a redirect are dropped by the epoch bit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fetchUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              run,
  input  logic              redirect,
  input  logic [15:0]       target,
  input  logic              take,
  input  logic              halted,
  memBusIf.requester        fetchBus,
  output logic              instrValid,
  output cpuPkg::instrT     instr,
  output logic [15:0]       instrPc,
  output logic [15:0]       pc
);

  logic        pending;                   // Read granted, data not back
  logic        epoch;
  logic        pendEpoch;                 // Epoch of the read in flight
  logic [15:0] pendPc;
  logic        respOk;

  // Read only, next sequential address
  assign fetchBus.req   = run && !halted && !pending && (!instrValid || take);
  assign fetchBus.we    = 1'b0;
  assign fetchBus.addr  = pc;
  assign fetchBus.wdata = '0;

  assign respOk = fetchBus.rvalid && (pendEpoch == epoch);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc         <= '0;
      pending    <= 1'b0;
      epoch      <= 1'b0;
      pendEpoch  <= 1'b0;
      instrValid <= 1'b0;
    end else begin
      epoch <= epoch ^ redirect;          // Flush anything in flight
      if (redirect) pc <= target;
      else if (fetchBus.gnt) pc <= pc + 16'd2;
      if (fetchBus.gnt) begin
        pending   <= 1'b1;
        pendEpoch <= epoch;
      end else if (fetchBus.rvalid) begin
        pending <= 1'b0;
      end
      if (redirect) instrValid <= 1'b0;
      else if (respOk) instrValid <= 1'b1;
      else if (take) instrValid <= 1'b0;
    end
  end

  // Buffer payload
  always_ff @(posedge clk) begin
    if (fetchBus.gnt) pendPc <= pc;
    if (respOk) begin
      instr   <= fetchBus.rdata;
      instrPc <= pendPc;
    end
  end

  // BR targets come from registers, so this watches execute too
  pcEven: assert property (@(posedge clk) disable iff (!rstN) !pc[0]);

endmodule

//--- execUnit.sv
//////////////////////////////////////////////////////////////////////
// Single execute stage, one instruction at a time, no forwarding
// ADD/SUB/XOR set Z and N from the result, V only on ADD/SUB
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module execUnit (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         instrValid,
  input  cpuPkg::instrT                instr,
  input  logic [15:0]                  instrPc,
  output logic                         take,
  memBusIf.requester                   dataBus,
  output logic                         redirect,
  output logic [15:0]                  target,
  output logic                         hlt,
  output logic                         retireValid,
  output logic [15:0]                  retirePc,
  output logic                         wbEn,
  output logic [3:0]                   wbReg,
  output logic [cpuPkg::DataWidth-1:0] wbData,
  output logic                         storeEn,
  output logic [15:0]                  storeAddr,
  output logic [cpuPkg::DataWidth-1:0] storeData
);
  import cpuPkg::*;

  localparam int Msb = DataWidth - 1;

  opcodeT               op;
  logic [3:0]           rdIdx;
  logic [3:0]           rsIdx;
  logic [3:0]           rtIdx;            // Also shift amount, mem offset
  logic [DataWidth-1:0] regs [16];
  logic [DataWidth-1:0] rdVal, rsVal, rtVal;
  logic [DataWidth-1:0] sum, diff, aluRes;
  logic [15:0]          pcPlus2, brOff, memAddr;
  logic                 writesRd, setsFlags, ovf, condMet;
  logic                 isLw, isSw, active, loadWait;
  flagsT                flags;

  //////////////////////////////////////////////////////////////////////
  // Decode and register read
  assign op    = instr.rFmt.op;
  assign rdIdx = instr.rFmt.rd;
  assign rsIdx = instr.rFmt.rs;
  assign rtIdx = instr.rFmt.rt;
  assign rdVal = (rdIdx == 4'd0) ? '0 : regs[rdIdx];   // r0 reads zero
  assign rsVal = (rsIdx == 4'd0) ? '0 : regs[rsIdx];
  assign rtVal = (rtIdx == 4'd0) ? '0 : regs[rtIdx];

  assign isLw    = (op == opLw);
  assign isSw    = (op == opSw);
  assign active  = instrValid && !hlt;
  assign pcPlus2 = instrPc + 16'd2;
  assign brOff   = {{6{instr.bFmt.offset[8]}}, instr.bFmt.offset, 1'b0};
  assign memAddr = rsVal + {{11{rtIdx[3]}}, rtIdx, 1'b0};
  assign sum     = rsVal + rtVal;
  assign diff    = rsVal - rtVal;

  //////////////////////////////////////////////////////////////////////
  // ALU and writeback select
  always_comb begin
    aluRes    = '0;
    writesRd  = 1'b1;
    setsFlags = 1'b0;
    ovf       = 1'b0;
    case (op)
      opAdd: begin
        aluRes    = sum;
        setsFlags = 1'b1;
        ovf       = (rsVal[Msb] == rtVal[Msb]) && (sum[Msb] != rsVal[Msb]);
      end
      opSub: begin
        aluRes    = diff;
        setsFlags = 1'b1;
        ovf       = (rsVal[Msb] != rtVal[Msb]) && (diff[Msb] != rsVal[Msb]);
      end
      opXor: begin
        aluRes    = rsVal ^ rtVal;
        setsFlags = 1'b1;                 // V cleared
      end
      opSll:   aluRes = rsVal << rtIdx;
      opSra:   aluRes = $signed(rsVal) >>> rtIdx;
      opLlb:   aluRes = {rdVal[Msb:8], instr.iFmt.imm};
      opLhb:   aluRes = {instr.iFmt.imm, rdVal[7:0]};
      opPcs:   aluRes = pcPlus2;
      opLw:    aluRes = dataBus.rdata;    // Valid in the rvalid cycle
      default: writesRd = 1'b0;           // Stores, branches, HLT, no-ops
    endcase
  end

  // Condition against the flags left by earlier instructions
  always_comb begin
    case (instr.bFmt.cond)
      condNe:  condMet = !flags.z;
      condEq:  condMet = flags.z;
      condGt:  condMet = !flags.z && !flags.n;
      condLt:  condMet = flags.n;
      condGe:  condMet = flags.z || !flags.n;
      condLe:  condMet = flags.z || flags.n;
      condOv:  condMet = flags.v;
      default: condMet = 1'b1;            // Always
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Retire control and data memory
  assign take = active && (isLw ? (loadWait && dataBus.rvalid) : isSw ? dataBus.gnt : 1'b1);
  assign dataBus.req   = active && !loadWait && (isLw || isSw);
  assign dataBus.we    = isSw;
  assign dataBus.addr  = memAddr;
  assign dataBus.wdata = rdVal;

  assign redirect = take && (op == opB || op == opBr) && condMet;
  assign target   = (op == opBr) ? rsVal : pcPlus2 + brOff;

  // Retire trace
  assign retireValid = take;
  assign retirePc    = instrPc;
  assign wbEn        = take && writesRd;  // r0 writes shown, never read back
  assign wbReg       = rdIdx;
  assign wbData      = aluRes;
  assign storeEn     = take && isSw;
  assign storeAddr   = memAddr;
  assign storeData   = rdVal;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs     <= '{default: '0};
      flags    <= '0;
      loadWait <= 1'b0;
      hlt      <= 1'b0;
    end else begin
      if (wbEn) regs[wbReg] <= wbData;
      if (take && setsFlags) begin
        flags.z <= (aluRes == '0);
        flags.v <= ovf;
        flags.n <= aluRes[Msb];
      end
      if (dataBus.gnt && isLw) loadWait <= 1'b1;
      else if (dataBus.rvalid) loadWait <= 1'b0;
      if (take && op == opHlt) hlt <= 1'b1;   // Sticky until reset
    end
  end

  // Load data comes back only while a load waits for it
  rvalidOnlyForLoad: assert property (@(posedge clk) disable iff (!rstN)
    dataBus.rvalid |-> loadWait);

endmodule

//--- memArbiter.sv
//////////////////////////////////////////////////////////////////////
// Fixed priority loader > data > fetch, loader is write only
// Addresses wrap modulo 2*MemWords bytes before reaching memory
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module memArbiter #(
  parameter int MemWords = 1024
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         progWe,
  input  logic [15:0]                  progAddr,
  input  logic [cpuPkg::DataWidth-1:0] progData,
  memBusIf.arbiter                     fetchBus,
  memBusIf.arbiter                     dataBus,
  memBusIf.requester                   memBus
);
  import cpuPkg::*;

  logic [15:0]          muxAddr;
  logic [DataWidth-1:0] muxWdata;
  logic                 pendData;         // Owner of the read in flight
  logic                 pendFetch;

  always_comb begin
    if (progWe) begin
      memBus.we = 1'b1;
      muxAddr   = progAddr;
      muxWdata  = progData;
    end else if (dataBus.req) begin
      memBus.we = dataBus.we;
      muxAddr   = dataBus.addr;
      muxWdata  = dataBus.wdata;
    end else begin
      memBus.we = fetchBus.we;
      muxAddr   = fetchBus.addr;
      muxWdata  = fetchBus.wdata;
    end
  end

  assign memBus.req   = progWe || dataBus.req || fetchBus.req;
  assign memBus.addr  = 16'(32'(muxAddr) % (2 * MemWords));
  assign memBus.wdata = muxWdata;

  // Fetch is the one left waiting
  assign dataBus.gnt  = memBus.gnt && !progWe && dataBus.req;
  assign fetchBus.gnt = memBus.gnt && !progWe && !dataBus.req && fetchBus.req;

  // Read data to both, valid only to its owner
  assign dataBus.rdata   = memBus.rdata;
  assign fetchBus.rdata  = memBus.rdata;
  assign dataBus.rvalid  = memBus.rvalid && pendData;
  assign fetchBus.rvalid = memBus.rvalid && pendFetch;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pendData  <= 1'b0;
      pendFetch <= 1'b0;
    end else begin
      pendData  <= dataBus.gnt && !dataBus.we;
      pendFetch <= fetchBus.gnt && !fetchBus.we;
    end
  end

  // Memory answers only reads granted here, each with one owner
  oneOwner: assert property (@(posedge clk) disable iff (!rstN)
    memBus.rvalid |-> $onehot({pendData, pendFetch}));
  gntNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    memBus.gnt |-> memBus.req);

endmodule

//--- unifiedMem.sv
//////////////////////////////////////////////////////////////////////
// Single port, program and data together, MemWords 2 to 32768
// Address must arrive already wrapped below 2*MemWords bytes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module unifiedMem #(
  parameter int MemWords = 1024
) (
  input  logic     clk,
  input  logic     rstN,
  memBusIf.arbiter memBus                 // Responder side
);
  import cpuPkg::*;

  localparam int AddrBits = $clog2(MemWords);

  logic [DataWidth-1:0] mem [MemWords];
  logic [AddrBits-1:0]  wordIdx;

  assign wordIdx    = memBus.addr[AddrBits:1];   // Byte lsb dropped
  assign memBus.gnt = memBus.req;                // Ready every cycle

  always_ff @(posedge clk) begin
    if (memBus.req && memBus.we) mem[wordIdx] <= memBus.wdata;
    if (memBus.req && !memBus.we) memBus.rdata <= mem[wordIdx];
  end

  // One cycle read latency
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) memBus.rvalid <= 1'b0;
    else memBus.rvalid <= memBus.req && !memBus.we;
  end

endmodule

//--- cpu.sv
//////////////////////////////////////////////////////////////////////
// Core top, fetch and execute sharing one memory through the arbiter
// Hold run low while the loader fills memory
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cpu #(
  parameter int MemWords = 1024
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         run,
  input  logic                         progWe,
  input  logic [15:0]                  progAddr,
  input  logic [cpuPkg::DataWidth-1:0] progData,
  output logic                         hlt,
  output logic [15:0]                  pcOut,
  output logic                         retireValid,
  output logic [15:0]                  retirePc,
  output logic                         wbEn,
  output logic [3:0]                   wbReg,
  output logic [cpuPkg::DataWidth-1:0] wbData,
  output logic                         storeEn,
  output logic [15:0]                  storeAddr,
  output logic [cpuPkg::DataWidth-1:0] storeData
);
  import cpuPkg::*;

  ////////////////////////////////////////////////////////////////////
  // Fetch to execute
  logic        instrValid, take, redirect;
  instrT       instr;
  logic [15:0] instrPc, target;

  memBusIf fetchBus ();
  memBusIf dataBus ();
  memBusIf memBus ();

  fetchUnit i_fetch (
    .clk, .rstN, .run, .redirect, .target, .take,
    .halted(hlt), .fetchBus, .instrValid, .instr, .instrPc, .pc(pcOut)
  );

  execUnit i_exec (
    .clk, .rstN, .instrValid, .instr, .instrPc, .take, .dataBus,
    .redirect, .target, .hlt, .retireValid, .retirePc, .wbEn, .wbReg,
    .wbData, .storeEn, .storeAddr, .storeData
  );

  ////////////////////////////////////////////////////////////////////
  // Shared memory
  memArbiter #(.MemWords(MemWords)) i_arbiter (
    .clk, .rstN, .progWe, .progAddr, .progData, .fetchBus, .dataBus, .memBus
  );

  unifiedMem #(.MemWords(MemWords)) i_mem (.clk, .rstN, .memBus);

endmodule

//--- tbClock.sv
//////////////////////////////////////////////////////////////////////
// Free-running clock, reset released 1 ns after its last low edge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tbClock #(
  parameter real PeriodNs    = 8.0,
  parameter int  ResetCycles = 10
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2.0) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;                          // Low from time 0
    repeat (ResetCycles) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

//--- cpuTb.sv
//////////////////////////////////////////////////////////////////////
// Random forward-only program, checked retire by retire on an ISA model
// r13 holds BR targets and r14 the data base, random code writes neither
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cpuTb;

  localparam int          MemWords  = 1024;
  localparam int          ProgLen   = 200;  // Final HLT included
  localparam int          PadWords  = 2;    // Extra HLT words past the end
  localparam logic [15:0] DataBase  = 16'h0600;
  localparam int          DataWords = 16;   // Reach of the 4-bit offset
  localparam int          HaltWatch = 20;
  localparam int          LoadWords = ProgLen + PadWords + DataWords;
  localparam logic [15:0] WritesRd  = 16'b0100_1101_0011_0111;  // Bit per opcode

  logic        clk, rstN;
  logic        run, progWe;
  logic [15:0] progAddr, progData;
  logic        hlt, retireValid, wbEn, storeEn;
  logic [15:0] pcOut, retirePc, wbData, storeAddr, storeData;
  logic [3:0]  wbReg;

  logic [15:0] prog [ProgLen + PadWords];
  logic        landing [ProgLen];         // Some branch jumps here
  logic [15:0] modelMem [MemWords];
  logic [15:0] mRegs [16];
  logic [15:0] mPc;
  logic        mZ, mV, mN;

  // Expected trace of the current retire
  logic [15:0] expPc, expWbData, expStoreAddr, expStoreData;
  logic        expWbEn, expStoreEn, expHalt;
  logic [3:0]  expWbReg;
  string       expName;

  int          errorCount, checkCount, cycleCount, timeoutLimit;
  logic        limitReady;
  logic [15:0] pcAtHalt;

  tbClock #(.PeriodNs(8.0), .ResetCycles(10)) i_clock (.clk, .rstN);

  cpu #(.MemWords(MemWords)) i_dut (
    .clk, .rstN, .run, .progWe, .progAddr, .progData, .hlt, .pcOut,
    .retireValid, .retirePc, .wbEn, .wbReg, .wbData,
    .storeEn, .storeAddr, .storeData
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  function automatic int wordIndex(logic [15:0] addr);
    return (int'(addr) % (2 * MemWords)) / 2;   // Byte address wraps
  endfunction

  // Odd multiplier keeps every word of the window distinct
  function automatic logic [15:0] fillWord(logic [15:0] addr);
    return (addr * 16'h9E37) ^ {addr[7:0], addr[15:8]} ^ 16'h3C5A;
  endfunction

  function automatic logic [15:0] readReg(logic [3:0] idx);
    return (idx == 4'd0) ? 16'h0000 : mRegs[idx];
  endfunction

  function automatic logic condHolds(logic [2:0] cond);
    case (cond)
      3'd0:    return !mZ;                // Not equal
      3'd1:    return mZ;
      3'd2:    return !mZ && !mN;         // Greater
      3'd3:    return mN;
      3'd4:    return !mN;                // Greater or equal
      3'd5:    return mZ || mN;
      3'd6:    return mV;
      default: return 1'b1;
    endcase
  endfunction

  function automatic string mnemonic(logic [3:0] op);
    case (op)
      4'h0:    return "ADD";
      4'h1:    return "SUB";
      4'h2:    return "XOR";
      4'h4:    return "SLL";
      4'h5:    return "SRA";
      4'h8:    return "LW";
      4'h9:    return "SW";
      4'hA:    return "LLB";
      4'hB:    return "LHB";
      4'hC:    return "B";
      4'hD:    return "BR";
      4'hE:    return "PCS";
      4'hF:    return "HLT";
      default: return "NOP";
    endcase
  endfunction

  // Any register but r13 and r14
  function automatic logic [3:0] pickDest();
    logic [3:0] r;
    r = 4'($urandom_range(0, 13));
    if (r == 4'd13) r = 4'd15;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Program generator
  task automatic buildProgram();
    int         p, off, t, kind;
    logic [3:0] op;
    foreach (landing[i]) landing[i] = 1'b0;
    prog[0] = {4'hA, 4'd14, DataBase[7:0]};     // Data base into r14
    prog[1] = {4'hB, 4'd14, DataBase[15:8]};
    p = 2;
    while (p < ProgLen - 1) begin
      kind = $urandom_range(0, 9);
      // BR group needs room and no branch landing inside it
      if (kind == 8 && (p > ProgLen - 4 || landing[p + 1] || landing[p + 2])) kind = 0;
      case (kind)
        0, 1, 2, 3: begin
          op = 4'($urandom_range(0, 4));
          if (op == 4'd3) op = 4'd5;      // ADD SUB XOR SLL SRA
          prog[p] = {op, pickDest(), 4'($urandom), 4'($urandom)};
        end
        4: prog[p] = {4'hA + 4'($urandom_range(0, 1)), pickDest(), 8'($urandom)};
        5: prog[p] = {4'h8, pickDest(), 4'd14, 4'($urandom)};
        6: prog[p] = {4'h9, 4'($urandom), 4'd14, 4'($urandom)};
        7: begin
          off = $urandom_range(0, (ProgLen - 2 - p < 6) ? ProgLen - 2 - p : 6);
          landing[p + 1 + off] = 1'b1;
          prog[p] = {4'hC, 3'($urandom), 9'(off)};
        end
        8: begin
          t = p + 3 + $urandom_range(0, (ProgLen - 4 - p < 7) ? ProgLen - 4 - p : 7);
          landing[t]  = 1'b1;
          prog[p]     = {4'hA, 4'd13, 8'(2 * t)};
          prog[p + 1] = {4'hB, 4'd13, 8'((2 * t) >> 8)};
          prog[p + 2] = {4'hD, 3'($urandom), 1'b0, 4'd13, 4'd0};
          p = p + 2;
        end
        default: prog[p] = {4'hE, pickDest(), 8'h00};   // PCS
      endcase
      p++;
    end
    for (int i = ProgLen - 1; i < ProgLen + PadWords; i++) prog[i] = 16'hF000;
  endtask

  // One loader write, mirrored into the model memory
  task automatic loadWord(logic [15:0] addr, logic [15:0] data);
    @(posedge clk);
    #1;
    progWe   = 1'b1;
    progAddr = addr;
    progData = data;
    modelMem[wordIndex(addr)] = data;
  endtask

  //////////////////////////////////////////////////////////////////////
  // ISA model, one instruction per call
  task automatic stepModel();
    logic [15:0] word, rsV, rtV, rdV, res, addr, nextPc;
    logic [3:0]  op, rd, rs, rt;
    int          wide;
    word = modelMem[wordIndex(mPc)];
    {op, rd, rs, rt} = word;
    rsV    = readReg(rs);
    rtV    = readReg(rt);
    rdV    = readReg(rd);
    res    = 16'h0000;
    nextPc = mPc + 16'd2;
    addr   = rsV + 16'($signed(rt) * 2);  // Offset in words
    expName    = $sformatf("%s@%04h", mnemonic(op), mPc);
    expPc      = mPc;
    expHalt    = 1'b0;
    expStoreEn = 1'b0;
    case (op)
      4'h0, 4'h1: begin
        if (op == 4'h0) wide = int'($signed(rsV)) + int'($signed(rtV));
        else wide = int'($signed(rsV)) - int'($signed(rtV));
        res = 16'(wide);
        mV  = (wide > 32767) || (wide < -32768);  // Outside signed range
      end
      4'h2: begin
        res = rsV ^ rtV;
        mV  = 1'b0;
      end
      4'h4: res = rsV << rt;
      4'h5: res = $signed(rsV) >>> rt;
      4'h8: res = modelMem[wordIndex(addr)];
      4'h9: begin
        expStoreEn = 1'b1;
        modelMem[wordIndex(addr)] = rdV;
      end
      4'hA: res = {rdV[15:8], word[7:0]};
      4'hB: res = {word[7:0], rdV[7:0]};
      4'hC: if (condHolds(word[11:9])) nextPc = mPc + 16'd2 + 16'($signed(word[8:0]) * 2);
      4'hD: if (condHolds(word[11:9])) nextPc = rsV;
      4'hE: res = mPc + 16'd2;
      4'hF: expHalt = 1'b1;
      default: ;                          // Undefined codes do nothing
    endcase
    expWbEn      = WritesRd[op];
    expWbReg     = rd;
    expWbData    = res;
    expStoreAddr = addr;
    expStoreData = rdV;
    if (expWbEn && rd != 4'd0) mRegs[rd] = res;
    if (op <= 4'h2) begin                 // Only ADD SUB XOR touch flags
      mZ = (res == 16'h0000);
      mN = res[15];
    end
    mPc = nextPc;
  endtask

  task automatic reportMismatch(string field, logic [15:0] expected, logic [15:0] actual);
    errorCount++;
    $display("FAILED %s %s expected 0x%04h actual 0x%04h", expName, field, expected, actual);
  endtask

  task automatic compareRetire();
    stepModel();
    checkCount++;
    if (retirePc !== expPc) reportMismatch("retirePc", expPc, retirePc);
    if (wbEn !== expWbEn) reportMismatch("wbEn", 16'(expWbEn), 16'(wbEn));
    if (expWbEn && wbReg !== expWbReg) reportMismatch("wbReg", 16'(expWbReg), 16'(wbReg));
    if (expWbEn && wbData !== expWbData) reportMismatch("wbData", expWbData, wbData);
    if (storeEn !== expStoreEn) reportMismatch("storeEn", 16'(expStoreEn), 16'(storeEn));
    if (expStoreEn && storeAddr !== expStoreAddr) reportMismatch("storeAddr", expStoreAddr, storeAddr);
    if (expStoreEn && storeData !== expStoreData) reportMismatch("storeData", expStoreData, storeData);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    logic [15:0] dataAddr;
    run        = 1'b0;
    progWe     = 1'b0;
    progAddr   = 16'h0000;
    progData   = 16'h0000;
    errorCount = 0;
    checkCount = 0;
    expHalt    = 1'b0;
    mPc        = 16'h0000;
    mZ         = 1'b0;
    mV         = 1'b0;
    mN         = 1'b0;
    foreach (mRegs[i]) mRegs[i] = 16'h0000;
    foreach (modelMem[i]) modelMem[i] = 16'h0000;
    void'($urandom(32'hecbd10c7));
    buildProgram();
    timeoutLimit = 10 + LoadWords + 10 * ProgLen + HaltWatch;
    limitReady   = 1'b1;

    wait (rstN === 1'b1);
    for (int i = 0; i < ProgLen + PadWords; i++) loadWord(16'(2 * i), prog[i]);
    for (int i = 0; i < DataWords; i++) begin
      dataAddr = DataBase - 16'd16 + 16'(2 * i);   // Window around r14
      loadWord(dataAddr, fillWord(dataAddr));
    end
    @(posedge clk);
    #1;
    progWe = 1'b0;
    run    = 1'b1;

    // Outputs settle well before the falling edge
    while (!expHalt) begin
      @(negedge clk);
      if (hlt) begin
        errorCount++;
        $display("ERROR: hlt rose before the model reached HLT");
        break;
      end
      if (retireValid) compareRetire();
    end

    @(negedge clk);
    if (!hlt) begin
      errorCount++;
      $display("ERROR: hlt did not rise after HLT retired");
    end
    pcAtHalt = pcOut;
    repeat (HaltWatch) begin
      @(negedge clk);
      if (retireValid) begin
        errorCount++;
        $display("ERROR: an instruction retired after HLT");
      end
      if (pcOut !== pcAtHalt) reportMismatch("pcOut", pcAtHalt, pcOut);
    end

    $display("Retires checked: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  end

  // Cycle limit covering reset, loading, execution and the halt watch
  initial begin
    cycleCount = 0;
    while (limitReady !== 1'b1 || cycleCount < timeoutLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    errorCount++;
    $display("ERROR: timeout after %0d cycles, the program never finished", cycleCount);
    $display("Retires checked: %0d, errors: %0d", checkCount, errorCount);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- cpu.f
cpuPkg.sv
memBusIf.sv
fetchUnit.sv
execUnit.sv
memArbiter.sv
unifiedMem.sv
cpu.sv
tbClock.sv
cpuTb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - cpuPkg.sv
      - memBusIf.sv
      - fetchUnit.sv
      - execUnit.sv
      - memArbiter.sv
      - unifiedMem.sv
      - cpu.sv
  - target: test
    files:
      - tbClock.sv
      - cpuTb.sv
